/* rtl/mulPkg.sv */
package mulPkg;

	////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////

	localparam int OpWidth   = 16;
	localparam int ProdWidth = 2 * OpWidth;

	// One partial-product row per multiplier bit
	localparam int NumPp = OpWidth;

	// Rows left after one carry-save layer over numRows rows.
	// Each group of three becomes sum plus carry, leftovers pass on.
	function automatic int csaOutRows(input int numRows);
		return 2 * (numRows / 3) + numRows % 3;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Stage structs
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                 valid;
		logic [OpWidth-1:0]   opA;
		logic [OpWidth-1:0]   opB;
	} mulReq_t;

	typedef struct packed {
		logic                            valid;
		logic [NumPp-1:0][ProdWidth-1:0] rows;
	} ppBank_t;

	typedef struct packed {
		logic                 valid;
		logic [ProdWidth-1:0] sumRow;
		logic [ProdWidth-1:0] carryRow;
	} csaPair_t;

	typedef struct packed {
		logic                 valid;
		logic [ProdWidth-1:0] product;
	} mulResp_t;

endpackage

/* rtl/ppDecode.sv */
`timescale 1ns/1ps

module ppDecode
	import mulPkg::*;
(
	input  logic    clk,
	input  logic    arstN,
	input  mulReq_t req,
	output ppBank_t ppBank
);

	////////////////////////////////////////////////////////////////////
	// Partial-product rows
	////////////////////////////////////////////////////////////////////

	// Row i holds opA gated by opB[i], weighted by 2**i
	logic [NumPp-1:0][ProdWidth-1:0] ppRows;
	logic [NumPp-1:0][OpWidth-1:0]   gated;

	always_comb begin
		for (int i = 0; i < NumPp; i++) begin
			gated[i]  = req.opA & {OpWidth{req.opB[i]}};
			// Widen first so the shift keeps the upper bits
			ppRows[i] = ProdWidth'(gated[i]) << i;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////////////

	// Valid follows the strobe every cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ppBank.valid <= 1'b0;
		end else begin
			ppBank.valid <= req.valid;
		end
	end

	// Rows load only on an accepted request, held otherwise
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ppBank.rows <= '0;
		end else if (req.valid) begin
			ppBank.rows <= ppRows;
		end
	end

endmodule

/* rtl/csaLayer.sv */
`timescale 1ns/1ps

module csaLayer
	import mulPkg::*;
#(
	parameter int NumRows = 3
) (
	input  logic [NumRows-1:0][ProdWidth-1:0]             inRows,
	output logic [csaOutRows(NumRows)-1:0][ProdWidth-1:0] outRows
);

	localparam int NumGroups = NumRows / 3;
	localparam int NumLeft   = NumRows % 3;

	////////////////////////////////////////////////////////////////////
	// Full-adder rows
	////////////////////////////////////////////////////////////////////

	// Group g takes rows 3g..3g+2 and drives rows 2g (sum), 2g+1 (carry)
	for (genvar g = 0; g < NumGroups; g++) begin : gGroup
		logic [ProdWidth-1:0] a;
		logic [ProdWidth-1:0] b;
		logic [ProdWidth-1:0] c;
		logic [ProdWidth-1:0] maj;

		assign a = inRows[3*g];
		assign b = inRows[3*g+1];
		assign c = inRows[3*g+2];

		// Bitwise full adder across the whole row
		assign maj = (a & b) | (a & c) | (b & c);

		assign outRows[2*g] = a ^ b ^ c;

		// Carry moves one column up, top carry falls off
		// the product never needs bit ProdWidth
		assign outRows[2*g+1] = {maj[ProdWidth-2:0], 1'b0};
	end

	////////////////////////////////////////////////////////////////////
	// Leftover rows
	////////////////////////////////////////////////////////////////////

	// One or two rows that did not fill a group go to the next layer
	for (genvar r = 0; r < NumLeft; r++) begin : gPass
		assign outRows[2*NumGroups+r] = inRows[3*NumGroups+r];
	end

endmodule

/* rtl/wallaceTree.sv */
`timescale 1ns/1ps

module wallaceTree
	import mulPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  ppBank_t  ppBank,
	output csaPair_t pair
);

	////////////////////////////////////////////////////////////////////
	// Row counts per layer
	////////////////////////////////////////////////////////////////////

	// 16 -> 11 -> 8 -> 6 -> 4 -> 3 -> 2
	localparam int Rows1 = csaOutRows(NumPp);
	localparam int Rows2 = csaOutRows(Rows1);
	localparam int Rows3 = csaOutRows(Rows2);
	localparam int Rows4 = csaOutRows(Rows3);
	localparam int Rows5 = csaOutRows(Rows4);
	localparam int Rows6 = csaOutRows(Rows5);

	logic [Rows1-1:0][ProdWidth-1:0] layer1;
	logic [Rows2-1:0][ProdWidth-1:0] layer2;
	logic [Rows3-1:0][ProdWidth-1:0] layer3;
	logic [Rows4-1:0][ProdWidth-1:0] layer4;
	logic [Rows5-1:0][ProdWidth-1:0] layer5;
	logic [Rows6-1:0][ProdWidth-1:0] layer6;

	////////////////////////////////////////////////////////////////////
	// Compression layers
	////////////////////////////////////////////////////////////////////

	csaLayer #(
		.NumRows (NumPp)
	) uLayer1 (
		.inRows  (ppBank.rows),
		.outRows (layer1)
	);

	csaLayer #(
		.NumRows (Rows1)
	) uLayer2 (
		.inRows  (layer1),
		.outRows (layer2)
	);

	csaLayer #(
		.NumRows (Rows2)
	) uLayer3 (
		.inRows  (layer2),
		.outRows (layer3)
	);

	csaLayer #(
		.NumRows (Rows3)
	) uLayer4 (
		.inRows  (layer3),
		.outRows (layer4)
	);

	csaLayer #(
		.NumRows (Rows4)
	) uLayer5 (
		.inRows  (layer4),
		.outRows (layer5)
	);

	// Last layer has one group, so row 0 is sum and row 1 is carry
	csaLayer #(
		.NumRows (Rows5)
	) uLayer6 (
		.inRows  (layer5),
		.outRows (layer6)
	);

	////////////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pair.valid <= 1'b0;
		end else begin
			pair.valid <= ppBank.valid;
		end
	end

	// Pair loads with its request only
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pair.sumRow   <= '0;
			pair.carryRow <= '0;
		end else if (ppBank.valid) begin
			pair.sumRow   <= layer6[0];
			pair.carryRow <= layer6[1];
		end
	end

endmodule

/* rtl/finalAdder.sv */
`timescale 1ns/1ps

module finalAdder
	import mulPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  csaPair_t pair,
	output mulResp_t resp
);

	////////////////////////////////////////////////////////////////////
	// Carry-propagate add
	////////////////////////////////////////////////////////////////////

	// Wraps at ProdWidth bits, the true product always fits
	logic [ProdWidth-1:0] sum;

	assign sum = pair.sumRow + pair.carryRow;

	////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resp.valid <= 1'b0;
		end else begin
			resp.valid <= pair.valid;
		end
	end

	// Product held until the next result
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resp.product <= '0;
		end else if (pair.valid) begin
			resp.product <= sum;
		end
	end

endmodule

/* rtl/wallaceMul.sv */
`timescale 1ns/1ps

module wallaceMul
	import mulPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  mulReq_t  req,
	output mulResp_t resp
);

	// Decode to execute
	ppBank_t  ppBank;

	// Execute to result
	csaPair_t pair;

	////////////////////////////////////////////////////////////////////
	// Three-stage pipeline, result three edges after the request
	////////////////////////////////////////////////////////////////////

	ppDecode uDecode (
		.clk    (clk),
		.arstN  (arstN),
		.req    (req),
		.ppBank (ppBank)
	);

	wallaceTree uTree (
		.clk    (clk),
		.arstN  (arstN),
		.ppBank (ppBank),
		.pair   (pair)
	);

	finalAdder uAdder (
		.clk   (clk),
		.arstN (arstN),
		.pair  (pair),
		.resp  (resp)
	);

endmodule

/* test/tbRef.svh */
`ifndef TB_REF_SVH
`define TB_REF_SVH

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

// Unsigned product of the two operands, kept to 32 bits
function automatic logic [31:0] refProduct(input logic [15:0] a, input logic [15:0] b);
	return {16'b0, a} * {16'b0, b};
endfunction

// One step of a 32-bit Galois LFSR, right shifting
// taps 32, 31, 29, 1
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
	if (state[0]) begin
		return (state >> 1) ^ 32'hD000_0001;
	end
	return state >> 1;
endfunction

//////////////////////////////////////////////////////////////////////
// Failure handling
//////////////////////////////////////////////////////////////////////

task automatic abortRun(input string reason);
	$display("%s", reason);
	$display("STATUS: FAIL");
	$fatal(1, "Simulation stopped");
endtask

// Compare a DUT value with its expected value
task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] expected);
	if (got !== expected) begin
		abortRun($sformatf("[ERROR] %0t ns: %s is %h, expected %h",
			$time, what, got, expected));
	end
endtask

`endif

/* test/tbWallaceMul.sv */
`timescale 1ns/1ps

module tbWallaceMul
	import mulPkg::*;
();

	localparam int NumCorners = 7;
	localparam int NumSingles = 200;
	localparam int NumBurst   = 300;
	localparam int TotalReqs  = NumCorners + NumSingles + NumBurst;

	// Edges from launching a request to its response
	localparam int Latency = 3;

	// Longest time any batch may take to come out
	localparam int DrainLimit = 50;

	logic     clk;
	logic     arstN;
	mulReq_t  req;
	mulResp_t resp;

	// LFSR state, one step per random bit
	logic [31:0] lfsrState;

	// Expected products and the edge that launched each request
	logic [31:0] expQ[$];
	int          reqEdgeQ[$];

	int edgeCount = 0;
	int reqCount  = 0;
	int respCount = 0;

	`include "tbRef.svh"

	wallaceMul dut (
		.clk   (clk),
		.arstN (arstN),
		.req   (req),
		.resp  (resp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		edgeCount <= edgeCount + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic randBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
	endtask

	task automatic driveReq(input logic [15:0] a, input logic [15:0] b);
		@(posedge clk);
		req.valid <= 1'b1;
		req.opA   <= a;
		req.opB   <= b;
	endtask

	// Operands stay put, only the strobe drops
	task automatic driveIdle();
		@(posedge clk);
		req.valid <= 1'b0;
	endtask

	task automatic waitDrain(input string what);
		int t;
		t = 0;
		while (expQ.size() != 0 && t < DrainLimit) begin
			@(posedge clk);
			t++;
		end
		if (expQ.size() != 0) begin
			abortRun($sformatf("Timed out after %0d cycles waiting for the %s results",
				DrainLimit, what));
		end
	endtask

	task automatic sendSingle(input logic [15:0] a, input logic [15:0] b, input string what);
		driveReq(a, b);
		driveIdle();
		waitDrain(what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitor and comparison
	//////////////////////////////////////////////////////////////////////

	// Runs on the falling edge where DUT inputs and outputs are settled
	always @(negedge clk) begin
		logic [31:0] expProd;
		int          reqEdge;
		if (arstN) begin
			// Retire first, a new request may launch in the same cycle
			if (resp.valid) begin
				if (expQ.size() == 0) begin
					abortRun("A response came out while no request was in flight");
				end else begin
					expProd = expQ.pop_front();
					reqEdge = reqEdgeQ.pop_front();
					respCount = respCount + 1;
					checkValue("response latency in edges", edgeCount - reqEdge, Latency);
					checkValue("product", resp.product, expProd);
				end
			end
			if (req.valid) begin
				expQ.push_back(refProduct(req.opA, req.opB));
				reqEdgeQ.push_back(edgeCount);
				reqCount = reqCount + 1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] gap;

		arstN     = 1'b0;
		req       = '0;
		lfsrState = 32'd71;

		repeat (3) @(posedge clk);
		arstN <= 1'b1;

		// Nothing may come out of an idle pipeline
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			checkValue("resp.valid while idle", {31'b0, resp.valid}, 32'd0);
		end

		// Corner operands
		sendSingle(16'h0000, 16'h0000, "zero times zero");
		sendSingle(16'h0000, 16'hFFFF, "zero times max");
		sendSingle(16'h0001, 16'hBEEF, "one times x");
		sendSingle(16'h5A5A, 16'h0001, "x times one");
		sendSingle(16'hFFFF, 16'hFFFF, "max times max");
		sendSingle(16'h8000, 16'h8000, "top bit squared");
		sendSingle(16'hFFFF, 16'h0001, "max times one");

		// Random single requests with idle gaps
		for (int i = 0; i < NumSingles; i++) begin
			randBits(16, a);
			randBits(16, b);
			sendSingle(a, b, "random single");
			randBits(2, gap);
			repeat (gap) @(posedge clk);
		end

		// One request per cycle keeps three in flight
		for (int i = 0; i < NumBurst; i++) begin
			randBits(16, a);
			randBits(16, b);
			driveReq(a, b);
		end
		driveIdle();
		waitDrain("back-to-back");

		// No stray result may trail the last one
		for (int i = 0; i < 2 * Latency; i++) begin
			@(negedge clk);
			checkValue("resp.valid after the last result", {31'b0, resp.valid}, 32'd0);
		end

		checkValue("request count", reqCount, TotalReqs);
		checkValue("response count", respCount, reqCount);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* tb.f */
+incdir+test
rtl/mulPkg.sv
rtl/ppDecode.sv
rtl/csaLayer.sv
rtl/wallaceTree.sv
rtl/finalAdder.sv
rtl/wallaceMul.sv
test/tbWallaceMul.sv

/* run.sh */
#!/bin/sh
# Build and run the multiplier testbench with Verilator.
# The run fails when the log holds the fail status line.

cd "$(dirname "$0")" || exit 1

logFile=sim.log
rm -rf obj_dir "$logFile" build.log

verilator --binary --timing --top-module tbWallaceMul -f tb.f -o simWallaceMul \
	> build.log 2>&1 \
	&& ./obj_dir/simWallaceMul > "$logFile" 2>&1 \
	|| echo "Build or simulation exited with an error" >> "$logFile"

grep -q "STATUS: FAIL" "$logFile" && { echo "Simulation failed, see $logFile"; exit 1; }
grep -q "STATUS: PASS" "$logFile" || { echo "No result found, see build.log"; exit 1; }
echo "Simulation passed"
exit 0
